// File: design/alu_unit.sv
// integer ALU
// single cycle operation with a registered result, which is the
// one-cycle common data bus broadcast

`timescale 1ns/10ps
`default_nettype none

module alu_unit (
	input  logic                clock,
	input  logic                reset,
	input  logic                issue_valid,
	input  ooo_pkg::alu_op_t    issue_op,
	input  ooo_pkg::data_t      issue_a,
	input  ooo_pkg::data_t      issue_b,
	input  ooo_pkg::rob_tag_t   issue_tag,
	output logic                cdb_valid,
	output ooo_pkg::rob_tag_t   cdb_tag,
	output ooo_pkg::data_t      cdb_value
);

	ooo_pkg::data_t result;

	always_comb begin
		case (issue_op)
			ooo_pkg::ALU_ADD: result = issue_a + issue_b;
			ooo_pkg::ALU_SUB: result = issue_a - issue_b;
			ooo_pkg::ALU_AND: result = issue_a & issue_b;
			ooo_pkg::ALU_OR:  result = issue_a | issue_b;
			ooo_pkg::ALU_XOR: result = issue_a ^ issue_b;
			// shift amount from b[4:0] only
			ooo_pkg::ALU_SLL: result = issue_a << issue_b[4:0];
			ooo_pkg::ALU_SRL: result = issue_a >> issue_b[4:0];
			ooo_pkg::ALU_SLT: result = ooo_pkg::data_t'($signed(issue_a) < $signed(issue_b));
			default:          result = '0;
		endcase
	end

	// cdb stage
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= issue_valid;
			cdb_tag   <= issue_tag;
			cdb_value <= result;
		end
	end

endmodule

`default_nettype wire

// File: design/dispatch_stage.sv
// dispatch stage
// holds one accepted instruction, then renames its operands through the
// map table, regfile, rob and cdb and dispatches it to rs and rob together

`timescale 1ns/10ps
`default_nettype none

module dispatch_stage (
	input  logic                clock,
	input  logic                reset,
	input  logic                inst_valid,
	input  ooo_pkg::alu_op_t    inst_op,
	input  ooo_pkg::reg_idx_t   inst_rd,
	input  ooo_pkg::reg_idx_t   inst_rs1,
	input  ooo_pkg::reg_idx_t   inst_rs2,
	input  logic                inst_use_imm,
	input  ooo_pkg::imm_t       inst_imm,
	output logic                inst_ready,
	dispatch_if.stage           disp,
	input  logic                rs_full,
	input  logic                rob_full,
	input  ooo_pkg::rob_tag_t   alloc_tag,
	input  logic                map_busy_a,
	input  ooo_pkg::rob_tag_t   map_tag_a,
	input  logic                map_busy_b,
	input  ooo_pkg::rob_tag_t   map_tag_b,
	output ooo_pkg::reg_idx_t   map_rs1,
	output ooo_pkg::reg_idx_t   map_rs2,
	input  ooo_pkg::data_t      rf_value_a,
	input  ooo_pkg::data_t      rf_value_b,
	input  logic                rob_ready_a,
	input  ooo_pkg::data_t      rob_value_a,
	input  logic                rob_ready_b,
	input  ooo_pkg::data_t      rob_value_b,
	input  logic                cdb_valid,
	input  ooo_pkg::rob_tag_t   cdb_tag,
	input  ooo_pkg::data_t      cdb_value
);

	localparam int IMM_W = $bits(ooo_pkg::imm_t);

	// held instruction, payload has no reset
	logic                held_valid;
	ooo_pkg::alu_op_t    held_op;
	ooo_pkg::reg_idx_t   held_rd;
	ooo_pkg::reg_idx_t   held_rs1;
	ooo_pkg::reg_idx_t   held_rs2;
	logic                held_use_imm;
	ooo_pkg::data_t      held_imm;

	logic                do_dispatch;
	// {ready, value} per operand
	logic [ooo_pkg::XLEN:0] res_a;
	logic [ooo_pkg::XLEN:0] res_b;

	// regfile if unmapped, then a finished rob entry, then this cycle's cdb
	function automatic logic [ooo_pkg::XLEN:0] resolve(
		input logic busy, input ooo_pkg::rob_tag_t tag, input ooo_pkg::data_t rf_value,
		input logic rob_ready, input ooo_pkg::data_t rob_value,
		input logic bus_valid, input ooo_pkg::rob_tag_t bus_tag,
		input ooo_pkg::data_t bus_value);
		if (!busy)
			return {1'b1, rf_value};
		if (rob_ready)
			return {1'b1, rob_value};
		if (bus_valid && bus_tag == tag)
			return {1'b1, bus_value};
		return {1'b0, rf_value};
	endfunction

	assign do_dispatch = held_valid && !rs_full && !rob_full;
	// empty now or emptying this cycle
	assign inst_ready = !held_valid || do_dispatch;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (inst_valid && inst_ready) begin
			held_valid   <= 1'b1;
			held_op      <= inst_op;
			held_rd      <= inst_rd;
			held_rs1     <= inst_rs1;
			held_rs2     <= inst_rs2;
			held_use_imm <= inst_use_imm;
			held_imm     <= {{(ooo_pkg::XLEN-IMM_W){inst_imm[IMM_W-1]}}, inst_imm};
		end else if (do_dispatch) begin
			held_valid <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// rename and allocate
	////////////////////////////////////////////////////////////////////////////

	assign map_rs1 = held_rs1;
	assign map_rs2 = held_rs2;

	assign res_a = resolve(map_busy_a, map_tag_a, rf_value_a, rob_ready_a, rob_value_a,
		cdb_valid, cdb_tag, cdb_value);
	assign res_b = resolve(map_busy_b, map_tag_b, rf_value_b, rob_ready_b, rob_value_b,
		cdb_valid, cdb_tag, cdb_value);

	assign disp.valid   = do_dispatch;
	assign disp.op      = held_op;
	assign disp.rd      = held_rd;
	assign disp.tag     = alloc_tag;
	assign disp.a_ready = res_a[ooo_pkg::XLEN];
	assign disp.a_tag   = map_tag_a;
	assign disp.a_value = res_a[ooo_pkg::XLEN-1:0];
	// immediate b never waits
	assign disp.b_ready = held_use_imm || res_b[ooo_pkg::XLEN];
	assign disp.b_tag   = map_tag_b;
	assign disp.b_value = held_use_imm ? held_imm : res_b[ooo_pkg::XLEN-1:0];

endmodule

`default_nettype wire

// File: design/map_table.sv
// register map table
// per architectural register busy bit and producing rob tag, set at
// dispatch and cleared when the matching rob entry commits

`timescale 1ns/10ps
`default_nettype none

module map_table (
	input  logic                clock,
	input  logic                reset,
	input  logic                set_en,
	input  ooo_pkg::reg_idx_t   set_rd,
	input  ooo_pkg::rob_tag_t   set_tag,
	commit_if.map               cm,
	input  ooo_pkg::reg_idx_t   rs1,
	input  ooo_pkg::reg_idx_t   rs2,
	output logic                busy_a,
	output ooo_pkg::rob_tag_t   tag_a,
	output logic                busy_b,
	output ooo_pkg::rob_tag_t   tag_b
);

	logic [ooo_pkg::NUM_REGS-1:0] busy;
	ooo_pkg::rob_tag_t            tags [ooo_pkg::NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			// only the newest writer may clear the entry
			if (cm.valid && busy[cm.rd] && tags[cm.rd] == cm.tag)
				busy[cm.rd] <= 1'b0;
			// later assignment, so a rename beats a clear
			if (set_en && set_rd != '0) begin
				busy[set_rd] <= 1'b1;
				tags[set_rd] <= set_tag;
			end
		end
	end

	assign busy_a = busy[rs1];
	assign tag_a  = tags[rs1];
	assign busy_b = busy[rs2];
	assign tag_b  = tags[rs2];

endmodule

`default_nettype wire

// File: design/ooo_core.sv
// ooo core top
// tomasulo style integer core: dispatch register and rename, one
// reservation station, one ALU on a single CDB, in-order commit from
// the ROB into the architectural register file

`timescale 1ns/10ps
`default_nettype none

module ooo_core #(
	parameter int ROB_DEPTH = 8,
	parameter int RS_DEPTH  = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                inst_valid,
	input  ooo_pkg::alu_op_t    inst_op,
	input  ooo_pkg::reg_idx_t   inst_rd,
	input  ooo_pkg::reg_idx_t   inst_rs1,
	input  ooo_pkg::reg_idx_t   inst_rs2,
	input  logic                inst_use_imm,
	input  ooo_pkg::imm_t       inst_imm,
	output logic                inst_ready,
	output logic                commit_valid,
	output ooo_pkg::reg_idx_t   commit_rd,
	output ooo_pkg::data_t      commit_value
);

	dispatch_if disp ();
	commit_if   cm ();

	// back-pressure
	logic                rs_full;
	logic                rob_full;
	ooo_pkg::rob_tag_t   alloc_tag;

	// operand lookup paths
	ooo_pkg::reg_idx_t   map_rs1;
	ooo_pkg::reg_idx_t   map_rs2;
	logic                map_busy_a;
	logic                map_busy_b;
	ooo_pkg::rob_tag_t   map_tag_a;
	ooo_pkg::rob_tag_t   map_tag_b;
	ooo_pkg::data_t      rf_value_a;
	ooo_pkg::data_t      rf_value_b;
	logic                rob_ready_a;
	logic                rob_ready_b;
	ooo_pkg::data_t      rob_value_a;
	ooo_pkg::data_t      rob_value_b;

	// issue and cdb
	logic                issue_valid;
	ooo_pkg::alu_op_t    issue_op;
	ooo_pkg::data_t      issue_a;
	ooo_pkg::data_t      issue_b;
	ooo_pkg::rob_tag_t   issue_tag;
	logic                cdb_valid;
	ooo_pkg::rob_tag_t   cdb_tag;
	ooo_pkg::data_t      cdb_value;

	dispatch_stage i_dispatch (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst_op(inst_op), .inst_rd(inst_rd),
		.inst_rs1(inst_rs1), .inst_rs2(inst_rs2),
		.inst_use_imm(inst_use_imm), .inst_imm(inst_imm),
		.inst_ready(inst_ready),
		.disp(disp.stage),
		.rs_full(rs_full), .rob_full(rob_full), .alloc_tag(alloc_tag),
		.map_busy_a(map_busy_a), .map_tag_a(map_tag_a),
		.map_busy_b(map_busy_b), .map_tag_b(map_tag_b),
		.map_rs1(map_rs1), .map_rs2(map_rs2),
		.rf_value_a(rf_value_a), .rf_value_b(rf_value_b),
		.rob_ready_a(rob_ready_a), .rob_value_a(rob_value_a),
		.rob_ready_b(rob_ready_b), .rob_value_b(rob_value_b),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
	);

	// rename state follows the dispatch strobe
	map_table i_map (
		.clock(clock), .reset(reset),
		.set_en(disp.valid), .set_rd(disp.rd), .set_tag(disp.tag),
		.cm(cm.map),
		.rs1(map_rs1), .rs2(map_rs2),
		.busy_a(map_busy_a), .tag_a(map_tag_a),
		.busy_b(map_busy_b), .tag_b(map_tag_b)
	);

	regfile i_regfile (
		.clock(clock), .reset(reset),
		.cm(cm.regfile),
		.rd_idx_a(map_rs1), .rd_idx_b(map_rs2),
		.rd_data_a(rf_value_a), .rd_data_b(rf_value_b)
	);

	reservation_station #(.RS_DEPTH(RS_DEPTH)) i_rs (
		.clock(clock), .reset(reset),
		.disp(disp.rs), .rs_full(rs_full),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag)
	);

	alu_unit i_alu (
		.clock(clock), .reset(reset),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
	);

	// rob read ports are addressed by the map table tags
	rob #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
		.clock(clock), .reset(reset),
		.disp(disp.rob), .rob_full(rob_full), .alloc_tag(alloc_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.read_tag_a(map_tag_a), .read_tag_b(map_tag_b),
		.read_ready_a(rob_ready_a), .read_value_a(rob_value_a),
		.read_ready_b(rob_ready_b), .read_value_b(rob_value_b),
		.cm(cm.rob),
		.commit_valid(commit_valid), .commit_rd(commit_rd),
		.commit_value(commit_value)
	);

endmodule

`default_nettype wire

// File: design/ooo_ifs.sv
// ooo core internal interfaces
// dispatch_if carries one renamed instruction to the RS and the ROB,
// commit_if carries the retiring ROB head to the regfile and map table

`timescale 1ns/10ps
`default_nettype none

interface dispatch_if;

	// dispatch strobe raised only when rs and rob both have room
	logic                valid;
	ooo_pkg::alu_op_t    op;
	ooo_pkg::reg_idx_t   rd;

	// operand a as a value or the tag it waits on
	logic                a_ready;
	ooo_pkg::rob_tag_t   a_tag;
	ooo_pkg::data_t      a_value;

	// operand b is always ready for immediates
	logic                b_ready;
	ooo_pkg::rob_tag_t   b_tag;
	ooo_pkg::data_t      b_value;

	// rob entry allocated to this instruction
	ooo_pkg::rob_tag_t   tag;

	modport stage (
		output valid, op, rd, a_ready, a_tag, a_value,
		output b_ready, b_tag, b_value, tag
	);

	modport rs (
		input valid, op, a_ready, a_tag, a_value,
		input b_ready, b_tag, b_value, tag
	);

	// rob only needs the destination and its own slot
	modport rob (
		input valid, rd, tag
	);

endinterface

interface commit_if;

	logic                valid;
	ooo_pkg::reg_idx_t   rd;
	ooo_pkg::data_t      value;
	ooo_pkg::rob_tag_t   tag;

	modport rob (
		output valid, rd, value, tag
	);

	modport regfile (
		input valid, rd, value
	);

	// map clears only when the stored tag still matches
	modport map (
		input valid, rd, tag
	);

endinterface

`default_nettype wire

// File: design/ooo_pkg.sv
// ooo core shared definitions
// data and index widths, the vector types built on them and the ALU
// operation encoding used from dispatch through to the ALU

`default_nettype none

package ooo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	// one data word
	localparam int XLEN = 32;
	// architectural registers, x0 hardwired to zero
	localparam int NUM_REGS = 32;

	// register value
	typedef logic [XLEN-1:0] data_t;
	// architectural register index
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	// raw immediate, sign extended at dispatch
	typedef logic [11:0] imm_t;
	// reorder buffer entry index, caps ROB_DEPTH at 16
	typedef logic [3:0] rob_tag_t;

	////////////////////////////////////////////////////////////////////////////
	// alu operations
	////////////////////////////////////////////////////////////////////////////

	// shifts use the low 5 bits of operand b
	// slt is a signed compare giving 1 or 0
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SLT = 3'd7
	} alu_op_t;

endpackage

`default_nettype wire

// File: design/regfile.sv
// architectural register file
// two combinational read ports and one write port from rob commit,
// x0 is never written so it always reads zero

`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  logic                clock,
	input  logic                reset,
	commit_if.regfile           cm,
	input  ooo_pkg::reg_idx_t   rd_idx_a,
	input  ooo_pkg::reg_idx_t   rd_idx_b,
	output ooo_pkg::data_t      rd_data_a,
	output ooo_pkg::data_t      rd_data_b
);

	ooo_pkg::data_t regs [ooo_pkg::NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ooo_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (cm.valid && cm.rd != '0) begin
			regs[cm.rd] <= cm.value;
		end
	end

	// committing values reach dispatch through the rob read port instead
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

// File: design/reservation_station.sv
// reservation station
// RS_DEPTH entries waiting on operands, woken by cdb tag match;
// each cycle the oldest entry with both operands ready goes to the ALU

`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
	parameter int RS_DEPTH = 4
) (
	input  logic                clock,
	input  logic                reset,
	dispatch_if.rs              disp,
	output logic                rs_full,
	input  logic                cdb_valid,
	input  ooo_pkg::rob_tag_t   cdb_tag,
	input  ooo_pkg::data_t      cdb_value,
	output logic                issue_valid,
	output ooo_pkg::alu_op_t    issue_op,
	output ooo_pkg::data_t      issue_a,
	output ooo_pkg::data_t      issue_b,
	output ooo_pkg::rob_tag_t   issue_tag
);

	// age is the count of younger entries, so it stays below RS_DEPTH
	typedef logic [$clog2(RS_DEPTH)-1:0] slot_t;
	typedef logic [$clog2(RS_DEPTH)-1:0] age_t;

	logic [RS_DEPTH-1:0]  used;
	logic [RS_DEPTH-1:0]  a_rdy;
	logic [RS_DEPTH-1:0]  b_rdy;
	ooo_pkg::alu_op_t     op_q   [RS_DEPTH];
	ooo_pkg::rob_tag_t    a_tag  [RS_DEPTH];
	ooo_pkg::rob_tag_t    b_tag  [RS_DEPTH];
	ooo_pkg::data_t       a_val  [RS_DEPTH];
	ooo_pkg::data_t       b_val  [RS_DEPTH];
	ooo_pkg::rob_tag_t    tag_q  [RS_DEPTH];
	age_t                 age_q  [RS_DEPTH];

	slot_t                issue_slot;
	slot_t                free_slot;

	////////////////////////////////////////////////////////////////////////////
	// select
	////////////////////////////////////////////////////////////////////////////

	// oldest ready wins
	always_comb begin
		issue_valid = 1'b0;
		issue_slot  = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (used[i] && a_rdy[i] && b_rdy[i] &&
			    (!issue_valid || age_q[i] > age_q[issue_slot])) begin
				issue_valid = 1'b1;
				issue_slot  = slot_t'(i);
			end
		end
	end

	// lowest free slot
	always_comb begin
		free_slot = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!used[i])
				free_slot = slot_t'(i);
		end
	end

	assign rs_full   = &used;
	assign issue_op  = op_q[issue_slot];
	assign issue_a   = a_val[issue_slot];
	assign issue_b   = b_val[issue_slot];
	assign issue_tag = tag_q[issue_slot];

	////////////////////////////////////////////////////////////////////////////
	// entry update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			used <= '0;
		end else begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				// cdb wakeup
				if (used[i] && cdb_valid && !a_rdy[i] && a_tag[i] == cdb_tag) begin
					a_rdy[i] <= 1'b1;
					a_val[i] <= cdb_value;
				end
				if (used[i] && cdb_valid && !b_rdy[i] && b_tag[i] == cdb_tag) begin
					b_rdy[i] <= 1'b1;
					b_val[i] <= cdb_value;
				end
				// older entries lose one younger on issue, all gain one on insert
				if (used[i])
					age_q[i] <= age_q[i] + age_t'(disp.valid) -
						age_t'(issue_valid && age_q[i] > age_q[issue_slot]);
			end
			if (issue_valid)
				used[issue_slot] <= 1'b0;
			// operands already bypassed against this cycle's cdb
			if (disp.valid) begin
				used[free_slot]  <= 1'b1;
				op_q[free_slot]  <= disp.op;
				a_rdy[free_slot] <= disp.a_ready;
				a_tag[free_slot] <= disp.a_tag;
				a_val[free_slot] <= disp.a_value;
				b_rdy[free_slot] <= disp.b_ready;
				b_tag[free_slot] <= disp.b_tag;
				b_val[free_slot] <= disp.b_value;
				tag_q[free_slot] <= disp.tag;
				age_q[free_slot] <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/rob.sv
// reorder buffer
// circular buffer allocated at the tail on dispatch, completed from the
// cdb, retired in order from the head; also serves dispatch operand reads

`timescale 1ns/10ps
`default_nettype none

module rob #(
	parameter int ROB_DEPTH = 8
) (
	input  logic                clock,
	input  logic                reset,
	dispatch_if.rob             disp,
	output logic                rob_full,
	output ooo_pkg::rob_tag_t   alloc_tag,
	input  logic                cdb_valid,
	input  ooo_pkg::rob_tag_t   cdb_tag,
	input  ooo_pkg::data_t      cdb_value,
	input  ooo_pkg::rob_tag_t   read_tag_a,
	input  ooo_pkg::rob_tag_t   read_tag_b,
	output logic                read_ready_a,
	output ooo_pkg::data_t      read_value_a,
	output logic                read_ready_b,
	output ooo_pkg::data_t      read_value_b,
	commit_if.rob               cm,
	output logic                commit_valid,
	output ooo_pkg::reg_idx_t   commit_rd,
	output ooo_pkg::data_t      commit_value
);

	// power of two depth, pointers wrap on their own
	localparam int PTR_W = $clog2(ROB_DEPTH);
	typedef logic [PTR_W-1:0]                 ptr_t;
	typedef logic [$clog2(ROB_DEPTH+1)-1:0]   cnt_t;

	ptr_t                 head;
	ptr_t                 tail;
	cnt_t                 count;
	logic [ROB_DEPTH-1:0] done;
	ooo_pkg::reg_idx_t    rd_q    [ROB_DEPTH];
	ooo_pkg::data_t       value_q [ROB_DEPTH];

	logic                 head_done;

	assign rob_full  = (count == cnt_t'(ROB_DEPTH));
	assign alloc_tag = ooo_pkg::rob_tag_t'(tail);
	assign head_done = (count != '0) && done[head];

	// operand reads, only asked for live tags from the map table
	assign read_ready_a = done[read_tag_a[PTR_W-1:0]];
	assign read_value_a = value_q[read_tag_a[PTR_W-1:0]];
	assign read_ready_b = done[read_tag_b[PTR_W-1:0]];
	assign read_value_b = value_q[read_tag_b[PTR_W-1:0]];

	////////////////////////////////////////////////////////////////////////////
	// commit
	////////////////////////////////////////////////////////////////////////////

	assign cm.valid = head_done;
	assign cm.rd    = rd_q[head];
	assign cm.value = value_q[head];
	assign cm.tag   = ooo_pkg::rob_tag_t'(head);

	assign commit_valid = head_done;
	assign commit_rd    = rd_q[head];
	assign commit_value = value_q[head];

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			// disp.tag is the tail handed out this cycle
			if (disp.valid) begin
				tail                         <= tail + 1'b1;
				done[disp.tag[PTR_W-1:0]]    <= 1'b0;
				rd_q[disp.tag[PTR_W-1:0]]    <= disp.rd;
			end
			// completion lands on the broadcast edge
			if (cdb_valid) begin
				done[cdb_tag[PTR_W-1:0]]    <= 1'b1;
				value_q[cdb_tag[PTR_W-1:0]] <= cdb_value;
			end
			if (head_done)
				head <= head + 1'b1;
			count <= count + cnt_t'(disp.valid) - cnt_t'(head_done);
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the ooo core testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_ooo_core \
	-o sim_ooo_core > build.log 2>&1 \
	&& ./obj_dir/sim_ooo_core > sim.log 2>&1 \
	|| echo "build or run failed, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null && exit 0 || exit 1

// File: tb.f
design/ooo_pkg.sv
design/ooo_ifs.sv
design/dispatch_stage.sv
design/map_table.sv
design/regfile.sv
design/reservation_station.sv
design/alu_unit.sv
design/rob.sv
design/ooo_core.sv
test/tb_ooo_core.sv

// File: test/tb_ooo_core.sv
// ooo core testbench
// drives directed and random ALU programs into the dispatch port,
// keeps a program-order reference model and checks every commit
// against it with concurrent assertions

`timescale 1ns/10ps
`default_nettype none

module tb_ooo_core;

	localparam int CLK_PERIOD     = 100;
	localparam int RESET_CYCLES   = 8;
	localparam int N_RANDOM       = 300;
	// directed part stays below 100 instructions
	localparam int MAX_INST       = N_RANDOM + 100;
	localparam int TIMEOUT_CYCLES = MAX_INST * 20 + 500;

	logic                clock;
	logic                reset;
	logic                inst_valid;
	ooo_pkg::alu_op_t    inst_op;
	ooo_pkg::reg_idx_t   inst_rd;
	ooo_pkg::reg_idx_t   inst_rs1;
	ooo_pkg::reg_idx_t   inst_rs2;
	logic                inst_use_imm;
	ooo_pkg::imm_t       inst_imm;
	logic                inst_ready;
	logic                commit_valid;
	ooo_pkg::reg_idx_t   commit_rd;
	ooo_pkg::data_t      commit_value;

	// reference model state
	ooo_pkg::data_t      ref_regs  [ooo_pkg::NUM_REGS];
	ooo_pkg::reg_idx_t   exp_rd    [MAX_INST];
	ooo_pkg::data_t      exp_value [MAX_INST];
	ooo_pkg::reg_idx_t   head_rd;
	ooo_pkg::data_t      head_value;
	int                  accepted;
	int                  commits;
	int                  errors;
	int                  stall_cycles;
	int unsigned         rng_state = 33;

	ooo_core #(.ROB_DEPTH(8), .RS_DEPTH(4)) i_dut (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst_op(inst_op), .inst_rd(inst_rd),
		.inst_rs1(inst_rs1), .inst_rs2(inst_rs2),
		.inst_use_imm(inst_use_imm), .inst_imm(inst_imm),
		.inst_ready(inst_ready),
		.commit_valid(commit_valid), .commit_rd(commit_rd),
		.commit_value(commit_value)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int unsigned lcg_step(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// upper bits of the lcg state since the low bits cycle too quickly
	task automatic draw(output int unsigned r);
		rng_state = lcg_step(rng_state);
		r = rng_state >> 16;
	endtask

	function automatic ooo_pkg::data_t sext_imm(input ooo_pkg::imm_t imm);
		return {{20{imm[11]}}, imm};
	endfunction

	// expected result straight from the operation rules
	function automatic ooo_pkg::data_t alu_model(input ooo_pkg::alu_op_t op,
		input ooo_pkg::data_t a, input ooo_pkg::data_t b);
		case (op)
			ooo_pkg::ALU_ADD: return a + b;
			ooo_pkg::ALU_SUB: return a - b;
			ooo_pkg::ALU_AND: return a & b;
			ooo_pkg::ALU_OR:  return a | b;
			ooo_pkg::ALU_XOR: return a ^ b;
			ooo_pkg::ALU_SLL: return a << b[4:0];
			ooo_pkg::ALU_SRL: return a >> b[4:0];
			ooo_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default:          return '0;
		endcase
	endfunction

	// called 1 ns after a rising edge, returns 1 ns after the accepting edge
	task automatic send_inst(input ooo_pkg::alu_op_t op, input int rd, input int rs1,
		input int rs2, input logic use_imm, input ooo_pkg::imm_t imm);
		logic taken;
		inst_valid   = 1'b1;
		inst_op      = op;
		inst_rd      = ooo_pkg::reg_idx_t'(rd);
		inst_rs1     = ooo_pkg::reg_idx_t'(rs1);
		inst_rs2     = ooo_pkg::reg_idx_t'(rs2);
		inst_use_imm = use_imm;
		inst_imm     = imm;
		taken        = 1'b0;
		while (!taken) begin
			// ready only moves after an edge, so mid-cycle is safe
			@(negedge clock);
			taken = inst_ready;
			if (!taken)
				stall_cycles++;
			@(posedge clock);
			#1;
		end
		inst_valid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		ooo_pkg::data_t a;
		ooo_pkg::data_t b;
		ooo_pkg::data_t v;
		if (!reset && inst_valid && inst_ready) begin
			a = ref_regs[inst_rs1];
			b = inst_use_imm ? sext_imm(inst_imm) : ref_regs[inst_rs2];
			v = alu_model(inst_op, a, b);
			// x0 keeps zero but the commit still reports v
			if (inst_rd != '0)
				ref_regs[inst_rd] = v;
			exp_rd[accepted]    <= inst_rd;
			exp_value[accepted] <= v;
			accepted            <= accepted + 1;
		end
		if (!reset && commit_valid)
			commits <= commits + 1;
	end

	// next commit expected in program order
	assign head_rd    = exp_rd[commits];
	assign head_value = exp_value[commits];

	////////////////////////////////////////////////////////////////////////////
	// assertions
	////////////////////////////////////////////////////////////////////////////

	reset_state: assert property (@(posedge clock) $fell(reset) |-> (inst_ready && !commit_valid))
		else begin
			errors++;
			$display("Mismatch at %0t: after reset inst_ready %b commit_valid %b",
				$time, $sampled(inst_ready), $sampled(commit_valid));
		end

	commit_order: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> (commits < accepted && commit_rd == head_rd &&
			commit_value == head_value))
		else begin
			errors++;
			$display("Mismatch at %0t: commit %0d of %0d gave rd %0d value %h, expected rd %0d value %h",
				$time, $sampled(commits), $sampled(accepted), $sampled(commit_rd),
				$sampled(commit_value), $sampled(head_rd), $sampled(head_value));
		end

	commit_known: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> !$isunknown({commit_rd, commit_value}))
		else begin
			errors++;
			$display("commit at %0t carries unknown bits", $time);
		end

	// ready only drops after an accept leaves an instruction held
	ready_drop: assert property (@(posedge clock) disable iff (reset)
		!inst_ready |-> ($past(inst_valid && inst_ready) || $past(!inst_ready)))
		else begin
			errors++;
			$display("Mismatch at %0t: inst_ready low with no instruction accepted", $time);
		end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int unsigned r;
		int unsigned s;
		clock        = 1'b0;
		reset        = 1'b1;
		inst_valid   = 1'b0;
		inst_op      = ooo_pkg::ALU_ADD;
		inst_rd      = '0;
		inst_rs1     = '0;
		inst_rs2     = '0;
		inst_use_imm = 1'b0;
		inst_imm     = '0;
		accepted     = 0;
		commits      = 0;
		errors       = 0;
		stall_cycles = 0;
		for (int i = 0; i < ooo_pkg::NUM_REGS; i++)
			ref_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;

		// never-written sources
		send_inst(ooo_pkg::ALU_ADD, 1, 5, 6, 1'b0, '0);
		send_inst(ooo_pkg::ALU_OR, 2, 7, 0, 1'b1, 12'h123);
		send_inst(ooo_pkg::ALU_SUB, 3, 8, 9, 1'b0, '0);

		// every op, register and immediate forms, with negative operands
		send_inst(ooo_pkg::ALU_ADD, 10, 0, 0, 1'b1, 12'hffb);
		send_inst(ooo_pkg::ALU_ADD, 11, 0, 0, 1'b1, 12'h007);
		send_inst(ooo_pkg::ALU_ADD, 12, 0, 0, 1'b1, 12'h7ff);
		idle(6);
		for (int i = 0; i < 8; i++) begin
			send_inst(ooo_pkg::alu_op_t'(i), 13, 10, 11, 1'b0, '0);
			send_inst(ooo_pkg::alu_op_t'(i), 14, 12, 0, 1'b1, (i % 2) ? 12'hf9c : 12'h01d);
			idle(1);
		end

		// back-to-back raw chains through in-flight producers
		for (int i = 0; i < 6; i++) begin
			send_inst(ooo_pkg::ALU_ADD, 15, 15, 0, 1'b1, 12'h001);
			send_inst(ooo_pkg::ALU_XOR, 16, 15, 16, 1'b0, '0);
		end

		// long dependent bursts to fill the rs and rob
		for (int round = 0; round < 2; round++) begin
			for (int i = 0; i < 16; i++)
				send_inst(ooo_pkg::alu_op_t'(i % 4), 17, 17, 15, 1'b0, '0);
			idle(4);
		end

		// newer writer renamed while the older one is still in flight
		for (int i = 0; i < 4; i++)
			send_inst(ooo_pkg::ALU_ADD, 20, 20, 17, 1'b0, '0);
		send_inst(ooo_pkg::ALU_ADD, 20, 0, 0, 1'b1, 12'h055);
		send_inst(ooo_pkg::ALU_ADD, 21, 20, 0, 1'b1, 12'h000);
		send_inst(ooo_pkg::ALU_ADD, 22, 0, 0, 1'b1, 12'h001);
		send_inst(ooo_pkg::ALU_ADD, 22, 0, 0, 1'b1, 12'h002);
		send_inst(ooo_pkg::ALU_ADD, 22, 0, 0, 1'b1, 12'h003);
		send_inst(ooo_pkg::ALU_SUB, 23, 22, 0, 1'b0, '0);

		// random program on x0..x7 for dense dependences
		for (int n = 0; n < N_RANDOM; n++) begin
			draw(r);
			draw(s);
			send_inst(ooo_pkg::alu_op_t'(r[2:0]), int'(r[5:3]), int'(r[8:6]),
				int'(r[11:9]), r[13:12] == 2'b00, ooo_pkg::imm_t'(s[11:0]));
			if (s[15:13] > 3'd4)
				idle(int'(s[15:13]) - 4);
		end

		// drain, then watch a while for stray commits
		wait (commits == accepted);
		idle(20);

		if (commits != accepted) begin
			errors++;
			$display("Mismatch at %0t: %0d commits for %0d accepted instructions",
				$time, commits, accepted);
		end
		if (stall_cycles == 0) begin
			errors++;
			$display("dispatch back-pressure was never seen during the bursts");
		end

		$display("errors %0d, accepted %0d, committed %0d, stall cycles %0d",
			errors, accepted, commits, stall_cycles);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog sized from the program length
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, %0d of %0d instructions committed",
			TIMEOUT_CYCLES, commits, accepted);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
